// File: frontend_top.f
rv_pkg.sv
fetch_unit.sv
fetch_queue.sv
idu.sv
decode_stage.sv
frontend_top.sv
tb_frontend.sv

// File: run.sh
#!/bin/sh
# Build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log \
	&& verilator --binary --timing --top-module tb_frontend -f frontend_top.f -o sim_frontend \
	&& ./obj_dir/sim_frontend | tee sim.log \
	|| exit 1
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1
exit 0

// File: tb_frontend.sv
`timescale 1ns/10ps

module tb_frontend;
	import rv_pkg::*;

	localparam int MEM_WORDS = 256;
	localparam int LIMIT     = 200;  // Cycles allowed per wait
	localparam logic [6:0] ILLEGAL_OPS [7] = '{CUSTOM_0, CUSTOM_1, CUSTOM_2, CUSTOM_3,
		RESERVED_0, RESERVED_1, RESERVED_2};

	logic            clk;
	logic            reset;
	logic            hold;
	logic [31:0]     imem_rdata = 32'h0;
	logic            imem_req;
	logic [PC_W-1:0] imem_addr;
	logic            dec_valid;
	logic [PC_W-1:0] dec_pc;
	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [4:0]      rd;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [XLEN-1:0] imm;
	inst_fmt_t       fmt;

	logic [31:0]     mem [MEM_WORDS];
	logic [63:0]     exp_q [$];      // Program counters still to be decoded
	logic            held_last;
	integer          seed;
	int              errors;
	int              tests;

	frontend_top #(
		.QUEUE_DEPTH (4)
	) dut0 (
		.clk        (clk),
		.reset      (reset),
		.hold       (hold),
		.imem_rdata (imem_rdata),
		.imem_req   (imem_req),
		.imem_addr  (imem_addr),
		.dec_valid  (dec_valid),
		.dec_pc     (dec_pc),
		.opcode     (opcode),
		.funct3     (funct3),
		.funct7     (funct7),
		.rd         (rd),
		.rs1        (rs1),
		.rs2        (rs2),
		.imm        (imm),
		.fmt        (fmt)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Instruction memory with one cycle of latency
	always @(posedge clk) begin
		if (imem_req) begin
			imem_rdata <= mem[imem_addr[9:2]];
		end
	end

	// Format class by the major opcode row
	function automatic inst_fmt_t ref_fmt(input logic [31:0] w);
		if (w[1:0] != 2'b11) begin
			return FMT_ILLEGAL;
		end
		case (w[6:2])
			5'h00, 5'h01, 5'h03, 5'h04, 5'h06, 5'h19, 5'h1c: return FMT_I;
			5'h08, 5'h09:                                    return FMT_S;
			5'h0b, 5'h0c, 5'h0e, 5'h14:                      return FMT_R;
			5'h10, 5'h11, 5'h12, 5'h13:                      return FMT_R4;
			5'h05, 5'h0d:                                    return FMT_U;
			5'h18:                                           return FMT_B;
			5'h1b:                                           return FMT_J;
			default:                                         return FMT_ILLEGAL;
		endcase
	endfunction

	function automatic logic [63:0] ref_imm(input logic [31:0] w);
		logic [63:0] s;
		s = {64{w[31]}};  // Sign fill
		case (ref_fmt(w))
			FMT_I:   return {s[63:12], w[31:20]};
			FMT_S:   return {s[63:12], w[31:25], w[11:7]};
			FMT_B:   return {s[63:12], w[7], w[30:25], w[11:8], 1'b0};
			FMT_U:   return {s[63:32], w[31:12], 12'h000};
			FMT_J:   return {s[63:20], w[19:12], w[20], w[30:21], 1'b0};
			default: return 64'd0;
		endcase
	endfunction

	task automatic check_field(input string name, input logic [63:0] exp_val,
		input logic [63:0] act_val);
		if (act_val !== exp_val) begin
			$display("Fail %s expected %h got %h", name, exp_val, act_val);
			errors++;
		end
	endtask

	task automatic check_decode(input logic [63:0] exp_pc);
		logic [31:0] w;
		w = mem[exp_pc[9:2]];
		check_field("dec_pc", exp_pc, dec_pc);
		check_field("opcode", 64'(w[6:0]), 64'(opcode));
		check_field("rd", 64'(w[11:7]), 64'(rd));
		check_field("funct3", 64'(w[14:12]), 64'(funct3));
		check_field("rs1", 64'(w[19:15]), 64'(rs1));
		check_field("rs2", 64'(w[24:20]), 64'(rs2));
		check_field("funct7", 64'(w[31:25]), 64'(funct7));
		check_field("fmt", 64'(ref_fmt(w)), 64'(fmt));
		check_field("imm", ref_imm(w), imm);
	endtask

	// Background of addi x0, x0, index
	task automatic fill_mem();
		int i;
		for (i = 0; i < MEM_WORDS; i++) begin
			mem[i] = {4'h0, i[7:0], 13'h0000, 7'h13};
		end
	endtask

	task automatic pulse_reset();
		int k;
		@(posedge clk);
		reset <= 1'b1;
		hold  <= 1'b0;
		for (k = 1; k <= 3; k++) begin
			@(posedge clk);
			if (k == 3) begin
				reset <= 1'b0;
			end
			@(negedge clk);
			check_field("dec_valid", 64'h0, 64'(dec_valid));
			check_field("imem_req", 64'h0, 64'(imem_req));
		end
		held_last = 1'b0;
	endtask

	// Checks any decode output of one clock against the next expected pc
	task automatic step_cycle();
		@(negedge clk);
		if (held_last) begin
			check_field("dec_valid", 64'h0, 64'(dec_valid));  // No pop under hold
		end
		if (dec_valid === 1'b1) begin
			if (exp_q.size() > 0) begin
				check_decode(exp_q.pop_front());
			end
		end
		held_last = hold;
	endtask

	task automatic run_decode(input int remaining, input int limit);
		int cycles;
		cycles = 0;
		while (exp_q.size() > remaining && cycles < limit) begin
			step_cycle();
			cycles++;
		end
		if (exp_q.size() > remaining) begin
			$display("Timeout, decode stopped with %0d instructions still expected",
				exp_q.size());
			errors++;
		end
	endtask

	task automatic expect_linear(input int n);
		int i;
		exp_q.delete();
		for (i = 0; i < n; i++) begin
			exp_q.push_back(64'(4 * i));
		end
	endtask

	task automatic finish_test(input string name, input int first_err);
		tests++;
		$display("Test %s done with %0d errors", name, errors - first_err);
	endtask

	task automatic test_straight_line();
		int first_err;
		first_err = errors;
		fill_mem();
		mem[0] = 32'h002081b3;  // add x3, x1, x2
		mem[1] = 32'hfff30293;  // addi x5, x6, -1
		mem[2] = 32'h00743823;  // sd x7, 16(x8)
		mem[3] = 32'hfe000ee3;  // beq x0, x0, -4
		mem[4] = 32'h12345537;  // lui x10, 0x12345
		mem[5] = 32'h18208243;  // fmadd.s
		expect_linear(6);
		pulse_reset();
		run_decode(0, LIMIT);
		finish_test("straight_line", first_err);
	endtask

	task automatic test_random_words();
		int first_err;
		int i;
		logic [31:0] w;
		first_err = errors;
		fill_mem();
		for (i = 0; i < 40; i++) begin
			w = $random(seed);
			if (i % 4 == 0) begin
				w[6:0] = ILLEGAL_OPS[(i / 4) % 7];
			end
			if (w[6:0] == JAL) begin
				w[3] = 1'b0;  // Keeps the path linear
			end
			mem[i] = w;
		end
		expect_linear(40);
		pulse_reset();
		run_decode(0, LIMIT);
		finish_test("random_words", first_err);
	endtask

	task automatic test_jump_redirect();
		int first_err;
		first_err = errors;
		fill_mem();
		mem[2]  = 32'h018000ef;  // jal x1, +24 at pc 8
		mem[10] = 32'hfe1ff06f;  // jal x0, -32 at pc 40
		exp_q.delete();
		exp_q = '{64'd0, 64'd4, 64'd8, 64'd32, 64'd36, 64'd40, 64'd8, 64'd32, 64'd36, 64'd40};
		pulse_reset();
		run_decode(0, LIMIT);
		finish_test("jump_redirect", first_err);
	endtask

	task automatic test_back_pressure();
		int first_err;
		int i;
		first_err = errors;
		fill_mem();
		expect_linear(30);
		pulse_reset();
		run_decode(25, LIMIT);
		@(posedge clk);
		hold <= 1'b1;
		for (i = 0; i < 20; i++) begin
			step_cycle();
			if (i >= 8) begin
				check_field("imem_req", 64'h0, 64'(imem_req));  // Queue full by now
			end
		end
		@(posedge clk);
		hold <= 1'b0;
		run_decode(0, LIMIT);
		finish_test("back_pressure", first_err);
	endtask

	task automatic test_reset_state();
		int first_err;
		int cycles;
		first_err = errors;
		fill_mem();
		pulse_reset();
		cycles = 0;
		while (imem_req !== 1'b1 && cycles < 10) begin
			@(negedge clk);
			cycles++;
		end
		if (imem_req !== 1'b1) begin
			$display("Timeout, no fetch request came after reset");
			errors++;
		end else begin
			check_field("imem_addr", 64'h0, imem_addr);
		end
		finish_test("reset_state", first_err);
	endtask

	initial begin
		seed   = 64;
		errors = 0;
		tests  = 0;
		reset <= 1'b1;
		hold  <= 1'b0;
		test_straight_line();
		test_random_words();
		test_jump_redirect();
		test_back_pressure();
		test_reset_state();
		$display("Ran %0d tests with %0d errors", tests, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: frontend_top.sv
`timescale 1ns/10ps

module frontend_top #(
	parameter int QUEUE_DEPTH = 4  // Power of two, at least 2
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     hold,
	input  logic [31:0]              imem_rdata,
	output logic                     imem_req,
	output logic [rv_pkg::PC_W-1:0]  imem_addr,
	output logic                     dec_valid,
	output logic [rv_pkg::PC_W-1:0]  dec_pc,
	output logic [6:0]               opcode,
	output logic [2:0]               funct3,
	output logic [6:0]               funct7,
	output logic [4:0]               rd,
	output logic [4:0]               rs1,
	output logic [4:0]               rs2,
	output logic [rv_pkg::XLEN-1:0]  imm,
	output rv_pkg::inst_fmt_t        fmt
);
	import rv_pkg::*;

	localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;  // Holds 0 through QUEUE_DEPTH

	logic             push;
	logic [PC_W-1:0]  push_pc;
	logic [31:0]      push_inst;
	logic             pop;
	logic             empty;
	logic [CNT_W-1:0] count;
	logic [PC_W-1:0]  head_pc;
	logic [31:0]      head_inst;
	logic             redirect;
	logic [PC_W-1:0]  redirect_pc;

	fetch_unit #(
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.CNT_W       (CNT_W)
	) fetch0 (
		.clk         (clk),
		.reset       (reset),
		.count       (count),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.imem_rdata  (imem_rdata),
		.imem_req    (imem_req),
		.imem_addr   (imem_addr),
		.push        (push),
		.push_pc     (push_pc),
		.push_inst   (push_inst)
	);

	fetch_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.CNT_W       (CNT_W)
	) queue0 (
		.clk       (clk),
		.reset     (reset),
		.flush     (redirect),  // Wrong-path entries go on a jump
		.push      (push),
		.push_pc   (push_pc),
		.push_inst (push_inst),
		.pop       (pop),
		.empty     (empty),
		.count     (count),
		.head_pc   (head_pc),
		.head_inst (head_inst)
	);

	decode_stage decode0 (
		.clk         (clk),
		.reset       (reset),
		.hold        (hold),
		.empty       (empty),
		.head_pc     (head_pc),
		.head_inst   (head_inst),
		.pop         (pop),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.dec_valid   (dec_valid),
		.dec_pc      (dec_pc),
		.opcode      (opcode),
		.funct3      (funct3),
		.funct7      (funct7),
		.rd          (rd),
		.rs1         (rs1),
		.rs2         (rs2),
		.imm         (imm),
		.fmt         (fmt)
	);

endmodule

// File: decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     hold,
	input  logic                     empty,
	input  logic [rv_pkg::PC_W-1:0]  head_pc,
	input  logic [31:0]              head_inst,
	output logic                     pop,
	output logic                     redirect,
	output logic [rv_pkg::PC_W-1:0]  redirect_pc,
	output logic                     dec_valid,
	output logic [rv_pkg::PC_W-1:0]  dec_pc,
	output logic [6:0]               opcode,
	output logic [2:0]               funct3,
	output logic [6:0]               funct7,
	output logic [4:0]               rd,
	output logic [4:0]               rs1,
	output logic [4:0]               rs2,
	output logic [rv_pkg::XLEN-1:0]  imm,
	output rv_pkg::inst_fmt_t        fmt
);
	import rv_pkg::*;

	logic [6:0]      id_opcode;
	logic [2:0]      id_funct3;
	logic [6:0]      id_funct7;
	logic [4:0]      id_rd;
	logic [4:0]      id_rs1;
	logic [4:0]      id_rs2;
	logic [XLEN-1:0] id_imm;
	inst_fmt_t       id_fmt;

	idu idu0 (
		.inst   (head_inst),
		.opcode (id_opcode),
		.funct3 (id_funct3),
		.funct7 (id_funct7),
		.rs1    (id_rs1),
		.rs2    (id_rs2),
		.rd     (id_rd),
		.fmt    (id_fmt),
		.imm    (id_imm)
	);

	assign pop = ~empty & ~hold;  // One entry per cycle

	// JAL target resolved in the pop cycle
	assign redirect    = pop & (id_fmt == FMT_J);
	assign redirect_pc = head_pc + id_imm;

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= pop;
		end
	end

	// Decoded fields, held until the next pop
	always_ff @(posedge clk) begin
		if (pop) begin
			dec_pc <= head_pc;
			opcode <= id_opcode;
			funct3 <= id_funct3;
			funct7 <= id_funct7;
			rd     <= id_rd;
			rs1    <= id_rs1;
			rs2    <= id_rs2;
			imm    <= id_imm;
			fmt    <= id_fmt;
		end
	end

endmodule

// File: idu.sv
`timescale 1ns/10ps

module idu (
	input  logic [31:0]              inst,
	output logic [6:0]               opcode,
	output logic [2:0]               funct3,
	output logic [6:0]               funct7,
	output logic [4:0]               rs1,
	output logic [4:0]               rs2,
	output logic [4:0]               rd,
	output rv_pkg::inst_fmt_t        fmt,
	output logic [rv_pkg::XLEN-1:0]  imm
);
	import rv_pkg::*;

	// Fixed field positions
	assign opcode = inst[6:0];
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign funct7 = inst[31:25];

	always_comb begin
		case (opcode)
			LOAD:       fmt = FMT_I;
			LOAD_FP:    fmt = FMT_I;
			CUSTOM_0:   fmt = FMT_ILLEGAL;
			MISC_MEM:   fmt = FMT_I;        // FENCE
			OP_IMM:     fmt = FMT_I;
			AUIPC:      fmt = FMT_U;
			OP_IMM_32:  fmt = FMT_I;
			STORE:      fmt = FMT_S;
			STORE_FP:   fmt = FMT_S;
			CUSTOM_1:   fmt = FMT_ILLEGAL;
			AMO:        fmt = FMT_R;
			OP:         fmt = FMT_R;
			LUI:        fmt = FMT_U;
			OP_32:      fmt = FMT_R;
			MADD:       fmt = FMT_R4;
			MSUB:       fmt = FMT_R4;
			NMSUB:      fmt = FMT_R4;
			NMADD:      fmt = FMT_R4;
			OP_FP:      fmt = FMT_R;
			RESERVED_0: fmt = FMT_ILLEGAL;
			CUSTOM_2:   fmt = FMT_ILLEGAL;
			BRANCH:     fmt = FMT_B;
			JALR:       fmt = FMT_I;
			RESERVED_1: fmt = FMT_ILLEGAL;
			JAL:        fmt = FMT_J;
			SYSTEM:     fmt = FMT_I;        // CSR and ECALL
			RESERVED_2: fmt = FMT_ILLEGAL;
			CUSTOM_3:   fmt = FMT_ILLEGAL;
			default:    fmt = FMT_ILLEGAL;  // Low bits not 2'b11 or 48-bit rows
		endcase
	end

	// Immediate assembly, every layout signs from inst[31]
	always_comb begin
		case (fmt)
			FMT_I: begin
				imm = {{(XLEN-12){inst[31]}}, inst[31:20]};
			end
			FMT_S: begin
				imm = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
			end
			FMT_B: begin
				imm = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
					inst[11:8], 1'b0};
			end
			FMT_U: begin
				imm = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
			end
			FMT_J: begin
				imm = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
					inst[30:21], 1'b0};
			end
			default: begin
				imm = '0;                  // R, R4 and illegal carry none
			end
		endcase
	end

endmodule

// File: fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue #(
	parameter int QUEUE_DEPTH = 4,
	parameter int CNT_W       = 3
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     flush,
	input  logic                     push,
	input  logic [rv_pkg::PC_W-1:0]  push_pc,
	input  logic [31:0]              push_inst,
	input  logic                     pop,
	output logic                     empty,
	output logic [CNT_W-1:0]         count,
	output logic [rv_pkg::PC_W-1:0]  head_pc,
	output logic [31:0]              head_inst
);
	import rv_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	logic [PC_W-1:0]  pc_mem [QUEUE_DEPTH];
	logic [31:0]      inst_mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(QUEUE_DEPTH));

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	// Oldest entry is always on the head ports
	assign head_pc   = pc_mem[rd_ptr];
	assign head_inst = inst_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;                // Flush wins over push
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1; // Wraps at power of two
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

	// Storage array
	always_ff @(posedge clk) begin
		if (do_push && !flush) begin
			pc_mem[wr_ptr]   <= push_pc;
			inst_mem[wr_ptr] <= push_inst;
		end
	end

endmodule

// File: fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
	parameter int QUEUE_DEPTH = 4,
	parameter int CNT_W       = 3
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [CNT_W-1:0]         count,
	input  logic                     redirect,
	input  logic [rv_pkg::PC_W-1:0]  redirect_pc,
	input  logic [31:0]              imem_rdata,
	output logic                     imem_req,
	output logic [rv_pkg::PC_W-1:0]  imem_addr,
	output logic                     push,
	output logic [rv_pkg::PC_W-1:0]  push_pc,
	output logic [31:0]              push_inst
);
	import rv_pkg::*;

	logic [PC_W-1:0] pc;          // Next address to request
	logic [PC_W-1:0] pending_pc;  // Address of the request in flight
	logic            pending;     // Response due this cycle
	logic            fetch_en;    // Start-up delay after reset
	logic [CNT_W:0]  occupancy;
	logic            room;

	// Entries already queued plus the one whose answer lands now
	assign occupancy = {1'b0, count} + {{CNT_W{1'b0}}, pending};
	assign room      = (occupancy < (CNT_W+1)'(QUEUE_DEPTH));

	assign imem_req  = fetch_en & room;
	assign imem_addr = pc;

	// Memory answers one cycle after the request
	assign push      = pending;
	assign push_pc   = pending_pc;
	assign push_inst = imem_rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_en <= 1'b0;
			pending  <= 1'b0;
			pc       <= RESET_PC;
		end else begin
			fetch_en <= 1'b1;
			pending  <= imem_req & ~redirect;  // Wrong-path answer is dropped
			if (redirect) begin
				pc <= redirect_pc;             // Restart at the jump target
			end else if (imem_req) begin
				pc <= pc + PC_W'(4);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (imem_req) begin
			pending_pc <= pc;
		end
	end

endmodule

// File: rv_pkg.sv
package rv_pkg;

	localparam int XLEN = 64;                        // RV64 data width
	localparam int PC_W = XLEN;
	localparam logic [PC_W-1:0] RESET_PC = '0;       // First fetch address

	// Major opcode map, inst[6:2] selects the row and inst[1:0] is always 2'b11
	localparam logic [6:0] LOAD       = 7'b00000_11;
	localparam logic [6:0] LOAD_FP    = 7'b00001_11;
	localparam logic [6:0] CUSTOM_0   = 7'b00010_11;
	localparam logic [6:0] MISC_MEM   = 7'b00011_11;
	localparam logic [6:0] OP_IMM     = 7'b00100_11;
	localparam logic [6:0] AUIPC      = 7'b00101_11;
	localparam logic [6:0] OP_IMM_32  = 7'b00110_11;

	localparam logic [6:0] STORE      = 7'b01000_11;
	localparam logic [6:0] STORE_FP   = 7'b01001_11;
	localparam logic [6:0] CUSTOM_1   = 7'b01010_11;
	localparam logic [6:0] AMO        = 7'b01011_11;
	localparam logic [6:0] OP         = 7'b01100_11;
	localparam logic [6:0] LUI        = 7'b01101_11;
	localparam logic [6:0] OP_32      = 7'b01110_11;

	localparam logic [6:0] MADD       = 7'b10000_11;
	localparam logic [6:0] MSUB       = 7'b10001_11;
	localparam logic [6:0] NMSUB      = 7'b10010_11;
	localparam logic [6:0] NMADD      = 7'b10011_11;
	localparam logic [6:0] OP_FP      = 7'b10100_11;
	localparam logic [6:0] RESERVED_0 = 7'b10101_11;
	localparam logic [6:0] CUSTOM_2   = 7'b10110_11; // Also rv128

	localparam logic [6:0] BRANCH     = 7'b11000_11;
	localparam logic [6:0] JALR       = 7'b11001_11;
	localparam logic [6:0] RESERVED_1 = 7'b11010_11;
	localparam logic [6:0] JAL        = 7'b11011_11;
	localparam logic [6:0] SYSTEM     = 7'b11100_11;
	localparam logic [6:0] RESERVED_2 = 7'b11101_11;
	localparam logic [6:0] CUSTOM_3   = 7'b11110_11; // Also rv128

	// Instruction format class, selects the immediate layout
	typedef enum logic [2:0] {
		FMT_R       = 3'd0,
		FMT_I       = 3'd1,
		FMT_S       = 3'd2,
		FMT_B       = 3'd3,
		FMT_U       = 3'd4,
		FMT_J       = 3'd5,
		FMT_R4      = 3'd6,
		FMT_ILLEGAL = 3'd7  // Custom, reserved or unknown opcode
	} inst_fmt_t;

endpackage
